// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := epdc_tb
FLIST      := flist.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing -j 0
PASS_TEXT  := SIMULATION PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

# Output is captured in a shell variable and searched for the pass line
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// ==== flist.f ====
+incdir+include
src/epdc_pkg.sv
src/pix_fifo.sv
src/fb_memif.sv
src/caster.sv
src/epd_scan.sv
src/epdc_top.sv
verif/epdc_tb.sv

// ==== include/epdc_defines.svh ====
`ifndef EPDC_DEFINES_SVH
`define EPDC_DEFINES_SVH

// Panel geometry, active area only
`define EPDC_H_ACT 16
`define EPDC_V_ACT 4

// Gray level width and pixels packed per beat
`define EPDC_PIX_W 2
`define EPDC_PPB 4
// One beat is one source driver byte
`define EPDC_BEAT_W (`EPDC_PPB * `EPDC_PIX_W)

// Derived beat counts
`define EPDC_BEATS_LINE (`EPDC_H_ACT / `EPDC_PPB)
`define EPDC_BEATS_FRAME (`EPDC_BEATS_LINE * `EPDC_V_ACT)

// Input FIFO entries, power of two
`define EPDC_FIFO_DEPTH 4

`endif

// ==== src/caster.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "epdc_defines.svh"

module caster
    import epdc_pkg::*;
(
    input  wire              clk,
    input  wire              arst_n,
    // Target beats from the input FIFO
    input  wire pix_beat_t   tgt_beat,
    input  wire              tgt_valid,
    output logic             tgt_ready,
    // Stored state beats from the framebuffer
    input  wire pix_beat_t   bi_beat,
    input  wire              bi_valid,
    output logic             bi_ready,
    // Write-back to the framebuffer
    output pix_beat_t        bo_beat,
    output logic             bo_valid,
    // Drive bytes to the scan controller
    output drive_beat_t      drv_beat,
    output logic             drv_valid,
    input  wire              drv_ready
);

    drive_beat_t drv_d;
    pix_beat_t   nxt_d;
    drive_beat_t drv_q;
    pix_beat_t   bo_q;
    logic        drv_vld_q;
    logic        bo_stb_q;
    logic        room;
    logic        accept;

    // One gray step toward the target per frame
    function automatic void step_pix(
        input  logic [`EPDC_PIX_W-1:0] tgt,
        input  logic [`EPDC_PIX_W-1:0] st,
        output drive_e                 drv,
        output logic [`EPDC_PIX_W-1:0] nxt
    );
        if (tgt > st) begin
            drv = DRV_LIGHTEN;
            nxt = st + 1'b1;
        end else if (tgt < st) begin
            drv = DRV_DARKEN;
            nxt = st - 1'b1;
        end else begin
            drv = DRV_NONE;
            nxt = st;
        end
    endfunction

    // All four pixels in parallel
    always_comb begin
        step_pix(tgt_beat.p0, bi_beat.p0, drv_d.d0, nxt_d.p0);
        step_pix(tgt_beat.p1, bi_beat.p1, drv_d.d1, nxt_d.p1);
        step_pix(tgt_beat.p2, bi_beat.p2, drv_d.d2, nxt_d.p2);
        step_pix(tgt_beat.p3, bi_beat.p3, drv_d.d3, nxt_d.p3);
    end

    // Output slot free, or freed by the scan this cycle
    assign room = !drv_vld_q || drv_ready;
    assign accept = tgt_valid && bi_valid && room;
    // Same signal on both sides keeps target and state paired
    assign tgt_ready = accept;
    assign bi_ready = accept;

    assign drv_beat = drv_q;
    assign drv_valid = drv_vld_q;
    assign bo_beat = bo_q;
    assign bo_valid = bo_stb_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            drv_vld_q <= 1'b0;
            bo_stb_q  <= 1'b0;
        end else begin
            if (accept) begin
                drv_vld_q <= 1'b1;
            end else if (drv_ready) begin
                drv_vld_q <= 1'b0;
            end
            // Write-back is a single cycle strobe
            bo_stb_q <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            drv_q <= drv_d;
            bo_q  <= nxt_d;
        end
    end

endmodule

`default_nettype wire

// ==== src/epd_scan.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "epdc_defines.svh"

module epd_scan
    import epdc_pkg::*;
(
    input  wire              clk,
    input  wire              arst_n,
    input  wire              global_en,
    // Drive bytes from the caster
    input  wire drive_beat_t drv_beat,
    input  wire              drv_valid,
    output logic             drv_ready,
    // Frame start to the framebuffer
    output logic             b_trigger,
    output epd_pins_t        epd
);

    localparam int BW = $clog2(`EPDC_BEATS_LINE);
    localparam int LW = $clog2(`EPDC_V_ACT);
    localparam logic [BW-1:0] LAST_BYTE = BW'(`EPDC_BEATS_LINE - 1);
    localparam logic [LW-1:0] LAST_LINE = LW'(`EPDC_V_ACT - 1);

    scan_state_e   state_q;
    // Second half of an sdclk or gdclk period
    logic          phase_q;
    logic [BW-1:0] byte_cnt;
    logic [LW-1:0] line_cnt;
    epd_pins_t     epd_q;

    assign epd = epd_q;
    // Take a byte only at the start of a source clock period
    assign drv_ready = (state_q == SCAN_DATA) && !phase_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q   <= SCAN_IDLE;
            phase_q   <= 1'b0;
            byte_cnt  <= '0;
            line_cnt  <= '0;
            epd_q     <= '0;
            b_trigger <= 1'b0;
        end else begin
            // Strobes low unless set below
            b_trigger   <= 1'b0;
            epd_q.sdclk <= 1'b0;
            epd_q.sdle  <= 1'b0;
            epd_q.gdclk <= 1'b0;
            epd_q.gdsp  <= 1'b0;
            case (state_q)
                SCAN_IDLE: begin
                    if (global_en) begin
                        b_trigger  <= 1'b1;
                        epd_q.gdoe <= 1'b1;
                        epd_q.sdoe <= 1'b1;
                        byte_cnt   <= '0;
                        line_cnt   <= '0;
                        phase_q    <= 1'b0;
                        state_q    <= SCAN_DATA;
                    end
                end
                SCAN_DATA: begin
                    if (!phase_q) begin
                        // sdclk stays low while no byte is offered
                        if (drv_valid) begin
                            epd_q.sd    <= drv_beat;
                            epd_q.sdclk <= 1'b1;
                            phase_q     <= 1'b1;
                        end
                    end else begin
                        // Low half of sdclk
                        phase_q <= 1'b0;
                        if (byte_cnt == LAST_BYTE) begin
                            byte_cnt <= '0;
                            state_q  <= SCAN_LATCH;
                        end else begin
                            byte_cnt <= byte_cnt + 1'b1;
                        end
                    end
                end
                SCAN_LATCH: begin
                    epd_q.sdle <= 1'b1;
                    state_q    <= SCAN_GATE;
                end
                SCAN_GATE: begin
                    if (!phase_q) begin
                        epd_q.gdclk <= 1'b1;
                        // Start pulse rides on the first gate clock
                        epd_q.gdsp  <= (line_cnt == '0);
                        phase_q     <= 1'b1;
                    end else begin
                        phase_q <= 1'b0;
                        if (line_cnt == LAST_LINE) begin
                            // Frame done, outputs off until next start
                            line_cnt   <= '0;
                            epd_q.gdoe <= 1'b0;
                            epd_q.sdoe <= 1'b0;
                            state_q    <= SCAN_IDLE;
                        end else begin
                            line_cnt <= line_cnt + 1'b1;
                            state_q  <= SCAN_DATA;
                        end
                    end
                end
                default: begin
                    state_q <= SCAN_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== src/epdc_pkg.sv ====
`default_nettype none
`include "epdc_defines.svh"

package epdc_pkg;

    // Four gray levels, pixel 0 in the low bits
    typedef struct packed {
        logic [`EPDC_PIX_W-1:0] p3;
        logic [`EPDC_PIX_W-1:0] p2;
        logic [`EPDC_PIX_W-1:0] p1;
        logic [`EPDC_PIX_W-1:0] p0;
    } pix_beat_t;

    // Per pixel source drive code
    typedef enum logic [1:0] {
        DRV_NONE    = 2'd0,
        DRV_DARKEN  = 2'd1,
        DRV_LIGHTEN = 2'd2
    } drive_e;

    // Panel source byte, pixel 0 in the low bits
    typedef struct packed {
        drive_e d3;
        drive_e d2;
        drive_e d1;
        drive_e d0;
    } drive_beat_t;

    typedef enum logic [1:0] {
        SCAN_IDLE,
        SCAN_DATA,
        SCAN_LATCH,
        SCAN_GATE
    } scan_state_e;

    // EPD panel pins
    typedef struct packed {
        logic                    gdoe;
        logic                    gdclk;
        logic                    gdsp;
        logic                    sdclk;
        logic                    sdle;
        logic                    sdoe;
        logic [`EPDC_BEAT_W-1:0] sd;
    } epd_pins_t;

endpackage

`default_nettype wire

// ==== src/epdc_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module epdc_top
    import epdc_pkg::*;
(
    input  wire            clk,
    input  wire            arst_n,
    input  wire            global_en,
    // Target pixel input
    input  wire pix_beat_t vin_beat,
    input  wire            vin_valid,
    output logic           vin_ready,
    // Panel pins
    output epd_pins_t      epd
);

    // Target path
    wire pix_beat_t   tgt_beat;
    wire              tgt_valid;
    wire              tgt_ready;
    // Framebuffer read and write-back
    wire pix_beat_t   bi_beat;
    wire              bi_valid;
    wire              bi_ready;
    wire pix_beat_t   bo_beat;
    wire              bo_valid;
    // Drive path and frame trigger
    wire drive_beat_t drv_beat;
    wire              drv_valid;
    wire              drv_ready;
    wire              b_trigger;

    pix_fifo pix_fifo (
        .clk      (clk),
        .arst_n   (arst_n),
        .wr_beat  (vin_beat),
        .wr_valid (vin_valid),
        .wr_ready (vin_ready),
        .rd_beat  (tgt_beat),
        .rd_valid (tgt_valid),
        .rd_ready (tgt_ready)
    );

    fb_memif fb_memif (
        .clk       (clk),
        .arst_n    (arst_n),
        .b_trigger (b_trigger),
        .bi_beat   (bi_beat),
        .bi_valid  (bi_valid),
        .bi_ready  (bi_ready),
        .bo_beat   (bo_beat),
        .bo_valid  (bo_valid)
    );

    caster caster (
        .clk       (clk),
        .arst_n    (arst_n),
        .tgt_beat  (tgt_beat),
        .tgt_valid (tgt_valid),
        .tgt_ready (tgt_ready),
        .bi_beat   (bi_beat),
        .bi_valid  (bi_valid),
        .bi_ready  (bi_ready),
        .bo_beat   (bo_beat),
        .bo_valid  (bo_valid),
        .drv_beat  (drv_beat),
        .drv_valid (drv_valid),
        .drv_ready (drv_ready)
    );

    epd_scan epd_scan (
        .clk       (clk),
        .arst_n    (arst_n),
        .global_en (global_en),
        .drv_beat  (drv_beat),
        .drv_valid (drv_valid),
        .drv_ready (drv_ready),
        .b_trigger (b_trigger),
        .epd       (epd)
    );

endmodule

`default_nettype wire

// ==== src/fb_memif.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "epdc_defines.svh"

module fb_memif
    import epdc_pkg::*;
(
    input  wire            clk,
    input  wire            arst_n,
    // Frame start from the scan controller
    input  wire            b_trigger,
    // Stored state out to the caster
    output pix_beat_t      bi_beat,
    output logic           bi_valid,
    input  wire            bi_ready,
    // Write-back strobe, always accepted
    input  wire pix_beat_t bo_beat,
    input  wire            bo_valid
);

    localparam int N = `EPDC_BEATS_FRAME;
    localparam int AW = $clog2(N);
    localparam logic [AW-1:0] LAST = AW'(N - 1);

    // Current panel state, one beat per entry
    pix_beat_t     mem [N];
    logic [AW-1:0] rd_ptr;
    logic [AW-1:0] wr_ptr;
    // Frame read still in progress
    logic          rd_active;

    assign bi_valid = rd_active;
    assign bi_beat = mem[rd_ptr];

    // Panel starts out all black after reset
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < N; i++) begin
                mem[i] <= '0;
            end
        end else if (bo_valid) begin
            mem[wr_ptr] <= bo_beat;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_ptr    <= '0;
            wr_ptr    <= '0;
            rd_active <= 1'b0;
        end else if (b_trigger) begin
            // Restart both pointers at beat 0
            rd_ptr    <= '0;
            wr_ptr    <= '0;
            rd_active <= 1'b1;
        end else begin
            if (bi_valid && bi_ready) begin
                rd_ptr <= rd_ptr + 1'b1;
                // Last beat of the frame handed out
                if (rd_ptr == LAST) begin
                    rd_active <= 1'b0;
                end
            end
            // Write-back trails the read side by at least one beat
            if (bo_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/pix_fifo.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "epdc_defines.svh"

module pix_fifo
    import epdc_pkg::*;
(
    input  wire            clk,
    input  wire            arst_n,
    // Write side
    input  wire pix_beat_t wr_beat,
    input  wire            wr_valid,
    output logic           wr_ready,
    // Read side
    output pix_beat_t      rd_beat,
    output logic           rd_valid,
    input  wire            rd_ready
);

    localparam int DEPTH = `EPDC_FIFO_DEPTH;
    localparam int AW = $clog2(DEPTH);
    localparam logic [AW:0] FULL = (AW + 1)'(DEPTH);

    pix_beat_t     mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    // One extra bit so full and empty differ
    logic [AW:0]   count;
    logic          do_wr;
    logic          do_rd;

    assign wr_ready = (count != FULL);
    assign rd_valid = (count != '0);
    // Head entry shown directly, no read latency
    assign rd_beat = mem[rd_ptr];
    assign do_wr = wr_valid && wr_ready;
    assign do_rd = rd_valid && rd_ready;

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_beat;
        end
    end

    // Pointers wrap on their own, depth is a power of two
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leaves count alone
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== verif/epdc_tb.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "epdc_defines.svh"

module epdc_tb
    import epdc_pkg::*;
();

    localparam int N_TESTS = 6;
    localparam int PPB = `EPDC_PPB;
    localparam int H_ACT = `EPDC_H_ACT;
    localparam int V_ACT = `EPDC_V_ACT;
    localparam int BEATS_LINE = `EPDC_BEATS_LINE;
    localparam int BEATS_FRAME = `EPDC_BEATS_FRAME;
    // Wait limits in clock cycles
    localparam int READY_LIMIT = 500;
    localparam int FRAME_LIMIT = 5000;
    localparam int QUIET_CYCLES = 30;

    logic      clk;
    logic      arst_n;
    logic      global_en;
    pix_beat_t vin_beat;
    logic      vin_valid;
    logic      vin_ready;
    epd_pins_t epd;

    // Test table: target line, frame count, random stalls,
    // non-NONE bytes expected in the last frame (-1 for any)
    string       row_name   [N_TESTS];
    logic [31:0] row_line   [N_TESTS];
    int          row_frames [N_TESTS];
    bit          row_stall  [N_TESTS];
    int          row_active [N_TESTS];

    // Panel state as the model sees it, black after reset
    logic [1:0]  model [H_ACT*V_ACT] = '{default: 2'd0};
    logic [31:0] cur_line = '0;
    string       cur_name = "";
    int          errors = 0;
    int          test_errors = 0;
    int          passed = 0;
    int          failed = 0;
    bit          timed_out = 1'b0;

    // Monitor counters
    int   line_bytes = 0;
    int   frame_lines = 0;
    int   frame_gates = 0;
    int   frame_starts = 0;
    int   frame_bytes = 0;
    int   act_bytes = 0;
    int   last_active = 0;
    int   frames_done = 0;
    logic prev_sdclk = 1'b0;
    logic prev_sdle = 1'b0;
    logic prev_gdclk = 1'b0;
    logic prev_gdoe = 1'b0;

    epdc_top DUT (
        .clk       (clk),
        .arst_n    (arst_n),
        .global_en (global_en),
        .vin_beat  (vin_beat),
        .vin_valid (vin_valid),
        .vin_ready (vin_ready),
        .epd       (epd)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic report_mismatch(input string what, input int exp, input int act);
        $display("FAILED %s: %s expected 'h%0h actual 'h%0h", cur_name, what, exp, act);
        errors++;
        test_errors++;
    endtask

    task automatic note_failure(input string what);
        $display("ERROR %s: %s", cur_name, what);
        errors++;
        test_errors++;
    endtask

    task automatic set_row(input int idx, input string name, input logic [31:0] line,
                           input int frames, input bit stall, input int active);
        row_name[idx]   = name;
        row_line[idx]   = line;
        row_frames[idx] = frames;
        row_stall[idx]  = stall;
        row_active[idx] = active;
    endtask

    task automatic load_table();
        // Converge on white, then one full darken step
        set_row(0, "all3_converge", 32'hFFFF_FFFF, 4, 1'b0, 0);
        set_row(1, "all0_darken", 32'h0000_0000, 1, 1'b0, 16);
        // Checkerboard 0/3, pixel 0 dark
        set_row(2, "checker", 32'hCCCC_CCCC, 2, 1'b0, 16);
        // Ramp 0,1,2,3 settles within three frames
        set_row(3, "ramp_settle", 32'hE4E4_E4E4, 3, 1'b0, 0);
        set_row(4, "ramp_down_stall", 32'h1B1B_1B1B, 2, 1'b1, 16);
        set_row(5, "mixed_stall", 32'h72D8_1E9C, 3, 1'b1, -1);
    endtask

    // Expected source byte from model state, then step the model
    task automatic check_byte(input logic [7:0] got);
        logic [7:0] exp_byte;
        logic [1:0] tgt;
        logic [1:0] st;
        int         col;
        int         idx;
        int         k;
        exp_byte = '0;
        for (k = 0; k < PPB; k++) begin
            col = line_bytes * PPB + k;
            idx = frame_lines * H_ACT + col;
            tgt = cur_line[2*col +: 2];
            st  = model[idx];
            if (tgt > st) begin
                exp_byte[2*k +: 2] = DRV_LIGHTEN;
                model[idx] = st + 2'd1;
            end else if (tgt < st) begin
                exp_byte[2*k +: 2] = DRV_DARKEN;
                model[idx] = st - 2'd1;
            end
        end
        if (got !== exp_byte) begin
            report_mismatch($sformatf("drive byte %0d", frame_bytes), int'(exp_byte), int'(got));
        end
        if (got != 8'd0) begin
            act_bytes++;
        end
    endtask

    // Pulse and frame bookkeeping, one sample per cycle
    task automatic watch_pins();
        if (epd.gdoe !== epd.sdoe) begin
            note_failure("gate and source output enables differ");
        end
        if (epd.gdoe && !prev_gdoe) begin
            line_bytes   = 0;
            frame_lines  = 0;
            frame_gates  = 0;
            frame_starts = 0;
            frame_bytes  = 0;
            act_bytes    = 0;
        end
        if ((epd.sdclk || epd.sdle || epd.gdclk) && !epd.gdoe) begin
            note_failure("panel clock pulse outside a frame");
        end
        if (epd.sdclk && !prev_sdclk) begin
            if (line_bytes < BEATS_LINE && frame_lines < V_ACT) begin
                check_byte(epd.sd);
            end else begin
                note_failure("source clock past the end of a line or frame");
            end
            line_bytes++;
            frame_bytes++;
        end
        if (epd.sdle && !prev_sdle) begin
            if (line_bytes != BEATS_LINE) begin
                report_mismatch("source clocks before latch", BEATS_LINE, line_bytes);
            end
            line_bytes = 0;
            frame_lines++;
        end
        if (epd.gdclk && !prev_gdclk) begin
            frame_gates++;
            if (epd.gdsp) begin
                frame_starts++;
            end
        end
        // Frame end checks on the fall of gdoe
        if (!epd.gdoe && prev_gdoe) begin
            if (frame_lines != V_ACT) begin
                report_mismatch("latch pulses per frame", V_ACT, frame_lines);
            end
            if (frame_gates != V_ACT) begin
                report_mismatch("gate clocks per frame", V_ACT, frame_gates);
            end
            if (frame_starts != 1) begin
                report_mismatch("gate start pulses per frame", 1, frame_starts);
            end
            if (frame_bytes != BEATS_FRAME) begin
                report_mismatch("source bytes per frame", BEATS_FRAME, frame_bytes);
            end
            last_active = act_bytes;
            frames_done++;
        end
    endtask

    // Monitor samples mid-cycle, away from both clock edges
    initial begin
        forever begin
            @(negedge clk);
            if (arst_n) begin
                watch_pins();
            end
            prev_sdclk = epd.sdclk;
            prev_sdle  = epd.sdle;
            prev_gdclk = epd.gdclk;
            prev_gdoe  = epd.gdoe;
        end
    end

    // Called 2 ns after a rising edge, returns at the same point
    task automatic send_beat(input pix_beat_t beat, input bit stall);
        int idle;
        int t;
        idle = 0;
        if (stall) begin
            idle = $urandom_range(3, 0);
        end
        repeat (idle) begin
            @(posedge clk);
            #2;
        end
        vin_beat  = beat;
        vin_valid = 1'b1;
        t = 0;
        while (!vin_ready && t < READY_LIMIT) begin
            @(posedge clk);
            #2;
            t++;
        end
        if (!vin_ready) begin
            note_failure("input FIFO never became ready");
            timed_out = 1'b1;
        end else begin
            // Ready is stable here, so the next edge transfers
            @(posedge clk);
            #2;
        end
        vin_valid = 1'b0;
    endtask

    task automatic close_test();
        if (test_errors == 0) begin
            $display("PASS %s", cur_name);
            passed++;
        end else begin
            $display("FAIL %s with %0d errors", cur_name, test_errors);
            failed++;
        end
    endtask

    task automatic run_test(input int i);
        int  goal;
        int  t;
        int  f;
        int  b;
        bit  woke;
        cur_name    = row_name[i];
        cur_line    = row_line[i];
        test_errors = 0;
        goal        = frames_done + row_frames[i];
        global_en   = 1'b1;
        for (f = 0; f < row_frames[i] && !timed_out; f++) begin
            for (b = 0; b < BEATS_FRAME && !timed_out; b++) begin
                send_beat(cur_line[8*(b % BEATS_LINE) +: 8], row_stall[i]);
            end
        end
        // Last frame is under way, so dropping enable stops after it
        global_en = 1'b0;
        t = 0;
        while (frames_done < goal && t < FRAME_LIMIT && !timed_out) begin
            @(posedge clk);
            #2;
            t++;
        end
        if (frames_done < goal && !timed_out) begin
            note_failure("frame did not complete in time");
            timed_out = 1'b1;
        end
        if (!timed_out && row_active[i] >= 0 && last_active != row_active[i]) begin
            report_mismatch("active bytes in last frame", row_active[i], last_active);
        end
        // Scan has to stay idle with enable low
        woke = 1'b0;
        for (t = 0; t < QUIET_CYCLES && !timed_out; t++) begin
            @(posedge clk);
            #2;
            if ((epd.gdoe || epd.gdsp) && !woke) begin
                note_failure("new frame started after global_en dropped");
                woke = 1'b1;
            end
        end
        close_test();
    endtask

    initial begin
        int i;
        arst_n    = 1'b0;
        global_en = 1'b0;
        vin_valid = 1'b0;
        vin_beat  = '0;
        void'($urandom(32'h7da5));
        load_table();
        cur_name = "reset";
        // Reset over two rising edges, pins must stay low
        repeat (2) begin
            @(posedge clk);
            #2;
            if (epd !== '0) begin
                report_mismatch("panel pins in reset", 0, int'(epd));
            end
        end
        arst_n = 1'b1;
        repeat (4) begin
            @(posedge clk);
            #2;
            if (epd !== '0) begin
                report_mismatch("panel pins after reset", 0, int'(epd));
            end
            if (vin_ready !== 1'b1) begin
                report_mismatch("input ready after reset", 1, int'(vin_ready));
            end
        end
        close_test();
        for (i = 0; i < N_TESTS && !timed_out; i++) begin
            run_test(i);
        end
        $display("Tests passed %0d, failed %0d, errors %0d", passed, failed, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
